//--- Bender.yml
package:
  name: ixu

sources:
  - common/ixu_cfg_pkg.sv
  - common/ixu_isa_pkg.sv
  - common/ixu_issue_if.sv
  - rtl/ixu_iram.sv
  - ixu_queue/ixu_issue_queue.sv
  - rtl/ixu_sc_pipe.sv
  - rtl/ixu_mc_pipe.sv
  - rtl/ixu.sv
  - target: test
    files:
      - bench/ixu_tb.sv

//--- bench/ixu_tb.sv
////////////////////
// IXU testbench
// Directed tests with a register-file model, shadow results and watchdog
////////////////////
`default_nettype none
`timescale 1ns/10ps

module ixu_tb
  import ixu_cfg_pkg::*;
  import ixu_isa_pkg::*;
();

  localparam int QUEUE_DEPTH = 8;
  localparam int MC_LATENCY  = 4;
  // Reset, the six tests in order, then margin
  localparam int RUN_CYCLES  = 8 + 120 + 40 + 80 + 80 + 80 + 80 + 100;

  logic    core_clock_i;
  logic    rst_n_i;
  logic    core_flush_i;
  logic    disp_valid_i;
  rob_id_t disp_rob_i;
  ixu_op_e disp_op_i;
  logic    disp_imm_i;
  xlen_t   disp_immediate_i;
  preg_t   disp_rs1_i;
  preg_t   disp_rs2_i;
  preg_t   disp_dest_i;
  logic    disp_rs1_rdy_i;
  logic    disp_rs2_rdy_i;
  logic    disp_busy_o;
  logic    ext_wkp_valid_i;
  preg_t   ext_wkp_dest_i;
  preg_t   sc_rs1_o;
  preg_t   sc_rs2_o;
  xlen_t   sc_rs1_data_i;
  xlen_t   sc_rs2_data_i;
  preg_t   mc_rs1_o;
  preg_t   mc_rs2_o;
  xlen_t   mc_rs1_data_i;
  xlen_t   mc_rs2_data_i;
  logic    sc_wb_valid_o;
  preg_t   sc_wb_dest_o;
  xlen_t   sc_wb_data_o;
  logic    sc_complete_o;
  rob_id_t sc_rob_o;
  logic    mc_wb_valid_o;
  preg_t   mc_wb_dest_o;
  xlen_t   mc_wb_data_o;
  logic    mc_complete_o;
  rob_id_t mc_rob_o;
  logic    excp_valid_o;
  rob_id_t excp_rob_o;

  // Register file model and expected contents
  xlen_t rf     [64];
  xlen_t shadow [64];

  int cyc = 0;
  int last_mc = -100;
  int checks = 0;
  int errors = 0;
  int cmp_cnt  [32];
  int cmp_cyc  [32];
  int disp_cyc [32];
  int excp_cnt [32];
  int wb_cnt   [64];

  ixu #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .MC_LATENCY  (MC_LATENCY)
  ) dut_i (
    .core_clock_i     (core_clock_i),
    .rst_n_i          (rst_n_i),
    .core_flush_i     (core_flush_i),
    .disp_valid_i     (disp_valid_i),
    .disp_rob_i       (disp_rob_i),
    .disp_op_i        (disp_op_i),
    .disp_imm_i       (disp_imm_i),
    .disp_immediate_i (disp_immediate_i),
    .disp_rs1_i       (disp_rs1_i),
    .disp_rs2_i       (disp_rs2_i),
    .disp_dest_i      (disp_dest_i),
    .disp_rs1_rdy_i   (disp_rs1_rdy_i),
    .disp_rs2_rdy_i   (disp_rs2_rdy_i),
    .disp_busy_o      (disp_busy_o),
    .ext_wkp_valid_i  (ext_wkp_valid_i),
    .ext_wkp_dest_i   (ext_wkp_dest_i),
    .sc_rs1_o         (sc_rs1_o),
    .sc_rs2_o         (sc_rs2_o),
    .sc_rs1_data_i    (sc_rs1_data_i),
    .sc_rs2_data_i    (sc_rs2_data_i),
    .mc_rs1_o         (mc_rs1_o),
    .mc_rs2_o         (mc_rs2_o),
    .mc_rs1_data_i    (mc_rs1_data_i),
    .mc_rs2_data_i    (mc_rs2_data_i),
    .sc_wb_valid_o    (sc_wb_valid_o),
    .sc_wb_dest_o     (sc_wb_dest_o),
    .sc_wb_data_o     (sc_wb_data_o),
    .sc_complete_o    (sc_complete_o),
    .sc_rob_o         (sc_rob_o),
    .mc_wb_valid_o    (mc_wb_valid_o),
    .mc_wb_dest_o     (mc_wb_dest_o),
    .mc_wb_data_o     (mc_wb_data_o),
    .mc_complete_o    (mc_complete_o),
    .mc_rob_o         (mc_rob_o),
    .excp_valid_o     (excp_valid_o),
    .excp_rob_o       (excp_rob_o)
  );

  initial begin
    core_clock_i = 1'b0;
    forever #4 core_clock_i = ~core_clock_i;
  end

  // Same-cycle read ports
  assign sc_rs1_data_i = rf[sc_rs1_o];
  assign sc_rs2_data_i = rf[sc_rs2_o];
  assign mc_rs1_data_i = rf[mc_rs1_o];
  assign mc_rs2_data_i = rf[mc_rs2_o];

  always @(posedge core_clock_i) begin
    if (sc_wb_valid_o) rf[sc_wb_dest_o] <= sc_wb_data_o;
    if (mc_wb_valid_o) rf[mc_wb_dest_o] <= mc_wb_data_o;
  end

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  // Completion monitor, cyc counts edges seen so far
  always @(posedge core_clock_i) begin
    if (rst_n_i) begin
      if (sc_complete_o) begin
        cmp_cnt[sc_rob_o]++;
        cmp_cyc[sc_rob_o] = cyc;
      end
      if (excp_valid_o) excp_cnt[excp_rob_o]++;
      if (sc_wb_valid_o) wb_cnt[sc_wb_dest_o]++;
      if (mc_wb_valid_o) wb_cnt[mc_wb_dest_o]++;
      if (mc_complete_o) begin
        check(cyc - last_mc >= MC_LATENCY, 1'b1, "mc completions closer than latency");
        last_mc = cyc;
        cmp_cnt[mc_rob_o]++;
        cmp_cyc[mc_rob_o] = cyc;
      end
    end
    cyc = cyc + 1;
  end

  // Reference results taken from the opcode definitions
  function automatic xlen_t expected_result(logic [3:0] op, xlen_t a, xlen_t b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      4'd0: return a + b;
      4'd1: return a - b;
      4'd2: return a & b;
      4'd3: return a | b;
      4'd4: return a ^ b;
      4'd5: return a << b[4:0];
      4'd6: return a >> b[4:0];
      4'd7: return {31'b0, $signed(a) < $signed(b)};
      4'd8: return prod[31:0];
      4'd9: return prod[63:32];
      default: return '0;
    endcase
  endfunction

  task automatic dispatch(input rob_id_t rob, input logic [3:0] op, input logic imm,
                          input xlen_t immv, input preg_t rs1, input preg_t rs2,
                          input preg_t dest, input logic rdy1, input logic rdy2);
    xlen_t b;
    while (disp_busy_o) begin
      @(posedge core_clock_i);
      #1;
    end
    b = imm ? immv : shadow[rs2];
    if (op <= 4'd9) shadow[dest] = expected_result(op, shadow[rs1], b);
    disp_cyc[rob]    = cyc;
    disp_valid_i     = 1'b1;
    disp_rob_i       = rob;
    disp_op_i        = ixu_op_e'(op);
    disp_imm_i       = imm;
    disp_immediate_i = immv;
    disp_rs1_i       = rs1;
    disp_rs2_i       = rs2;
    disp_dest_i      = dest;
    disp_rs1_rdy_i   = rdy1;
    disp_rs2_rdy_i   = rdy2;
    @(posedge core_clock_i);
    #1;
    disp_valid_i = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge core_clock_i);
    #1;
  endtask

  task automatic wait_complete(input rob_id_t rob);
    int n;
    n = 0;
    while (cmp_cnt[rob] == 0 && n < 40) begin
      @(posedge core_clock_i);
      #1;
      n++;
    end
    if (cmp_cnt[rob] == 0) begin
      errors++;
      $display("rob %0d did not complete within 40 cycles", rob);
    end
  endtask

  // Memory system result: value lands in the register file, then the wakeup
  task automatic load_reg(input preg_t tag, input xlen_t value);
    rf[tag] <= value;
    shadow[tag] = value;
  endtask

  task automatic pulse_ext(input preg_t tag, output int at);
    at              = cyc;
    ext_wkp_valid_i = 1'b1;
    ext_wkp_dest_i  = tag;
    @(posedge core_clock_i);
    #1;
    ext_wkp_valid_i = 1'b0;
  endtask

  task automatic clear_tracking();
    for (int i = 0; i < 32; i++) begin
      cmp_cnt[i]  = 0;
      excp_cnt[i] = 0;
    end
    for (int i = 0; i < 64; i++) wb_cnt[i] = 0;
  endtask

  task automatic check_op(input rob_id_t rob, input preg_t dest, input int min_lat);
    check(cmp_cnt[rob], 1, $sformatf("rob %0d completion count", rob));
    check(excp_cnt[rob], 0, $sformatf("rob %0d raised an exception", rob));
    check(rf[dest], shadow[dest], $sformatf("r%0d result of rob %0d", dest, rob));
    check(cmp_cyc[rob] - disp_cyc[rob] >= min_lat, 1'b1,
          $sformatf("rob %0d completed too early", rob));
  endtask

  task automatic report(input string name, input int err_before);
    if (errors == err_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic test_alu_ops();
    int    e0;
    preg_t s1;
    preg_t s2;
    e0 = errors;
    clear_tracking();
    // Codes 0..7 in register form, then again with an immediate
    for (int i = 0; i < 16; i++) begin
      s1 = preg_t'(1 + $urandom % 8);
      s2 = preg_t'(1 + $urandom % 8);
      dispatch(rob_id_t'(i), 4'(i % 8), i >= 8, $urandom, s1, s2, preg_t'(16 + i),
               1'b1, 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      wait_complete(rob_id_t'(i));
      check_op(rob_id_t'(i), preg_t'(16 + i), 2);
    end
    report("alu_ops", e0);
  endtask

  task automatic test_illegal();
    int    e0;
    xlen_t old;
    e0  = errors;
    clear_tracking();
    old = rf[40];
    dispatch(5'd20, 4'd12, 1'b0, '0, 6'd1, 6'd2, 6'd40, 1'b1, 1'b1);
    wait_complete(5'd20);
    check(excp_cnt[20], 1, "illegal op exception count");
    check(wb_cnt[40], 0, "illegal op wrote its destination");
    check(rf[40], old, "illegal op changed r40");
    report("illegal_op", e0);
  endtask

  task automatic test_dependency();
    int e0;
    int at;
    e0 = errors;
    clear_tracking();
    load_reg(6'd50, $urandom);
    dispatch(5'd1, 4'd0, 1'b0, '0, 6'd1, 6'd2, 6'd41, 1'b1, 1'b1);
    dispatch(5'd2, 4'd1, 1'b0, '0, 6'd41, 6'd3, 6'd42, 1'b0, 1'b1);
    // Waits on a tag that only the memory system produces
    dispatch(5'd3, 4'd4, 1'b0, '0, 6'd50, 6'd4, 6'd43, 1'b0, 1'b1);
    wait_complete(5'd2);
    // Consumer issues after the producer's writeback cycle, completes one later
    check(cmp_cyc[2] >= cmp_cyc[1] + 2, 1'b1,
          "consumer completed before producer writeback");
    wait_cycles(10);
    check(cmp_cnt[3], 0, "entry completed without its external wakeup");
    pulse_ext(6'd50, at);
    wait_complete(5'd3);
    check(cmp_cyc[3] > at, 1'b1, "entry completed before the external wakeup");
    check_op(5'd1, 6'd41, 2);
    check_op(5'd2, 6'd42, 2);
    check_op(5'd3, 6'd43, 2);
    report("dependency", e0);
  endtask

  task automatic test_multiply();
    int e0;
    e0 = errors;
    clear_tracking();
    dispatch(5'd4, 4'd8, 1'b0, '0, 6'd5, 6'd6, 6'd44, 1'b1, 1'b1);
    dispatch(5'd5, 4'd9, 1'b0, '0, 6'd5, 6'd6, 6'd45, 1'b1, 1'b1);
    dispatch(5'd6, 4'd8, 1'b0, '0, 6'd7, 6'd8, 6'd46, 1'b1, 1'b1);
    for (int i = 4; i < 7; i++) begin
      wait_complete(rob_id_t'(i));
      check_op(rob_id_t'(i), preg_t'(40 + i), 1 + MC_LATENCY);
    end
    report("multiply", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int at;
    int n;
    e0 = errors;
    clear_tracking();
    load_reg(6'd51, $urandom);
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      dispatch(rob_id_t'(8 + i), 4'(i % 8), 1'b0, '0, 6'd51, preg_t'(1 + i),
               preg_t'(52 + i), 1'b0, 1'b1);
    end
    check(disp_busy_o, 1'b1, "disp_busy_o low with a full queue");
    pulse_ext(6'd51, at);
    n = 0;
    while (disp_busy_o && n < 10) begin
      @(posedge core_clock_i);
      #1;
      n++;
    end
    check(disp_busy_o, 1'b0, "disp_busy_o still high after wakeup");
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      wait_complete(rob_id_t'(8 + i));
      check_op(rob_id_t'(8 + i), preg_t'(52 + i), 2);
    end
    report("backpressure", e0);
  endtask

  task automatic test_flush();
    int e0;
    int at;
    e0 = errors;
    clear_tracking();
    // Queue filled with entries parked on r60, one multiply in flight
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (i == QUEUE_DEPTH - 1) begin
        dispatch(5'd24, 4'd8, 1'b0, '0, 6'd1, 6'd2, 6'd63, 1'b1, 1'b1);
      end
      dispatch(rob_id_t'(16 + i), 4'(i % 8), 1'b0, '0, 6'd60, preg_t'(1 + i),
               preg_t'(52 + i), 1'b0, 1'b1);
    end
    check(disp_busy_o, 1'b1, "disp_busy_o low with a full queue before flush");
    core_flush_i = 1'b1;
    wait_cycles(1);
    core_flush_i = 1'b0;
    check(disp_busy_o, 1'b0, "disp_busy_o high after flush");
    pulse_ext(6'd60, at);
    wait_cycles(10);
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      check(cmp_cnt[16 + i], 0, $sformatf("flushed rob %0d completed", 16 + i));
      check(wb_cnt[52 + i], 0, $sformatf("flushed rob %0d wrote r%0d", 16 + i, 52 + i));
    end
    check(cmp_cnt[24], 0, "flushed multiply completed");
    check(wb_cnt[63], 0, "flushed multiply wrote r63");
    dispatch(5'd25, 4'd0, 1'b0, '0, 6'd1, 6'd2, 6'd47, 1'b1, 1'b1);
    wait_complete(5'd25);
    check_op(5'd25, 6'd47, 2);
    report("flush", e0);
  endtask

  initial begin
    int total;
    total = RUN_CYCLES;
    repeat (total) @(posedge core_clock_i);
    $display("Simulation timed out after %0d cycles", total);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(88095));
    rst_n_i          = 1'b0;
    core_flush_i     = 1'b0;
    disp_valid_i     = 1'b0;
    disp_rob_i       = '0;
    disp_op_i        = OP_ADD;
    disp_imm_i       = 1'b0;
    disp_immediate_i = '0;
    disp_rs1_i       = '0;
    disp_rs2_i       = '0;
    disp_dest_i      = '0;
    disp_rs1_rdy_i   = 1'b0;
    disp_rs2_rdy_i   = 1'b0;
    ext_wkp_valid_i  = 1'b0;
    ext_wkp_dest_i   = '0;
    for (int i = 0; i < 64; i++) load_reg(preg_t'(i), $urandom);
    repeat (8) @(posedge core_clock_i);
    #1;
    rst_n_i = 1'b1;
    wait_cycles(1);
    test_alu_ops();
    test_illegal();
    test_dependency();
    test_multiply();
    test_backpressure();
    test_flush();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- common/ixu_cfg_pkg.sv
////////////////////
// IXU configuration package
// Widths and vector types for ROB ids, physical registers and data
////////////////////
`default_nettype none

package ixu_cfg_pkg;

  // Data word
  localparam int XLEN = 32;

  // Reorder buffer id, 32 in-flight ops
  localparam int ROB_W = 5;

  // Physical register tag, 64 registers
  localparam int PREG_W = 6;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [ROB_W-1:0]  rob_id_t;
  typedef logic [PREG_W-1:0] preg_t;

endpackage

`default_nettype wire

//--- common/ixu_isa_pkg.sv
////////////////////
// IXU ISA package
// Opcode encoding and the rules that class and evaluate an opcode
////////////////////
`default_nettype none

package ixu_isa_pkg;
  import ixu_cfg_pkg::*;

  // Codes 10 to 15 are illegal
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SLT   = 4'd7,
    OP_MUL   = 4'd8,
    OP_MULHU = 4'd9
  } ixu_op_e;

  function automatic logic ixu_op_is_mc(ixu_op_e op);
    return (op == OP_MUL) || (op == OP_MULHU);
  endfunction

  function automatic logic ixu_op_is_legal(ixu_op_e op);
    return op <= OP_MULHU;
  endfunction

  // Single-cycle ALU result, zero for anything outside the ALU set
  function automatic xlen_t ixu_alu_eval(ixu_op_e op, xlen_t a, xlen_t b);
    xlen_t res;
    res = '0;
    case (op)
      OP_ADD: res = a + b;
      OP_SUB: res = a - b;
      OP_AND: res = a & b;
      OP_OR:  res = a | b;
      OP_XOR: res = a ^ b;
      // Shift amount is the low 5 bits of b
      OP_SLL: res = a << b[4:0];
      OP_SRL: res = a >> b[4:0];
      OP_SLT: res[0] = $signed(a) < $signed(b);
      default: res = '0;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

//--- common/ixu_issue_if.sv
////////////////////
// IXU issue bundle
// One issued op from the queue to an execution pipe
////////////////////
`default_nettype none
`timescale 1ns/10ps

interface ixu_issue_if
  import ixu_cfg_pkg::*;
();

  // One-cycle pulse per issued op, no acknowledge
  logic    valid;
  rob_id_t rob;
  preg_t   rs1;
  preg_t   rs2;
  preg_t   dest;

  modport queue_mp (
    output valid, rob, rs1, rs2, dest
  );

  modport pipe_mp (
    input valid, rob, rs1, rs2, dest
  );

endinterface

`default_nettype wire

//--- ixu.f
common/ixu_cfg_pkg.sv
common/ixu_isa_pkg.sv
common/ixu_issue_if.sv
rtl/ixu_iram.sv
ixu_queue/ixu_issue_queue.sv
rtl/ixu_sc_pipe.sv
rtl/ixu_mc_pipe.sv
rtl/ixu.sv
bench/ixu_tb.sv

//--- ixu_queue/ixu_issue_queue.sv
////////////////////
// IXU issue queue
// Tag wakeup, lowest-index select, one issue per pipe and cycle
////////////////////
`default_nettype none
`timescale 1ns/10ps

module ixu_issue_queue
  import ixu_cfg_pkg::*;
  import ixu_isa_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic    core_clock_i,
  input  logic    rst_n_i,
  input  logic    core_flush_i,
  // Dispatch
  input  logic    disp_valid_i,
  input  ixu_op_e disp_op_i,
  input  rob_id_t disp_rob_i,
  input  preg_t   disp_rs1_i,
  input  preg_t   disp_rs2_i,
  input  preg_t   disp_dest_i,
  input  logic    disp_rs1_rdy_i,
  input  logic    disp_rs2_rdy_i,
  output logic    disp_busy_o,
  // Wakeup
  input  logic    sc_wkp_valid_i,
  input  preg_t   sc_wkp_dest_i,
  input  logic    mc_wkp_valid_i,
  input  preg_t   mc_wkp_dest_i,
  input  logic    ext_wkp_valid_i,
  input  preg_t   ext_wkp_dest_i,
  input  logic    mc_busy_i,
  // Issue
  ixu_issue_if.queue_mp sc_issue,
  ixu_issue_if.queue_mp mc_issue
);

  localparam int IDX_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  logic [QUEUE_DEPTH-1:0] vld_q;
  logic [QUEUE_DEPTH-1:0] vld_d;
  logic [QUEUE_DEPTH-1:0] rdy1_q;
  logic [QUEUE_DEPTH-1:0] rdy2_q;
  logic [QUEUE_DEPTH-1:0] mc_q;
  rob_id_t                rob_q  [QUEUE_DEPTH];
  preg_t                  rs1_q  [QUEUE_DEPTH];
  preg_t                  rs2_q  [QUEUE_DEPTH];
  preg_t                  dest_q [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] sc_cand;
  logic [QUEUE_DEPTH-1:0] mc_cand;
  logic [IDX_W-1:0]       free_idx;
  logic [IDX_W-1:0]       sc_idx;
  logic [IDX_W-1:0]       mc_idx;
  logic                   disp_we;
  logic                   dup_rob;

  // A tag matches any of the three result broadcasts
  function automatic logic wake(preg_t tag);
    return (sc_wkp_valid_i && (sc_wkp_dest_i == tag)) ||
           (mc_wkp_valid_i && (mc_wkp_dest_i == tag)) ||
           (ext_wkp_valid_i && (ext_wkp_dest_i == tag));
  endfunction

  assign disp_busy_o = &vld_q;
  assign disp_we     = disp_valid_i && !disp_busy_o;

  // Multiply entries wait while the mc pipe is occupied
  assign sc_cand = vld_q & rdy1_q & rdy2_q & ~mc_q;
  assign mc_cand = vld_q & rdy1_q & rdy2_q & mc_q & {QUEUE_DEPTH{!mc_busy_i}};

  // Descending scan so the lowest index wins
  always_comb begin
    free_idx = '0;
    sc_idx   = '0;
    mc_idx   = '0;
    for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
      if (!vld_q[i]) free_idx = IDX_W'(i);
      if (sc_cand[i]) sc_idx = IDX_W'(i);
      if (mc_cand[i]) mc_idx = IDX_W'(i);
    end
  end

  always_comb begin
    vld_d = vld_q;
    if (|sc_cand) vld_d[sc_idx] = 1'b0;
    if (|mc_cand) vld_d[mc_idx] = 1'b0;
    if (disp_we) vld_d[free_idx] = 1'b1;
    if (core_flush_i) vld_d = '0;
  end

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  // Entry fields, qualified by vld_q
  always_ff @(posedge core_clock_i) begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      rdy1_q[i] <= rdy1_q[i] | wake(rs1_q[i]);
      rdy2_q[i] <= rdy2_q[i] | wake(rs2_q[i]);
    end
    if (disp_we) begin
      rob_q[free_idx]  <= disp_rob_i;
      rs1_q[free_idx]  <= disp_rs1_i;
      rs2_q[free_idx]  <= disp_rs2_i;
      dest_q[free_idx] <= disp_dest_i;
      mc_q[free_idx]   <= ixu_op_is_mc(disp_op_i);
      // Same-cycle wakeup is not lost
      rdy1_q[free_idx] <= disp_rs1_rdy_i | wake(disp_rs1_i);
      rdy2_q[free_idx] <= disp_rs2_rdy_i | wake(disp_rs2_i);
    end
  end

  assign sc_issue.valid = |sc_cand;
  assign sc_issue.rob   = rob_q[sc_idx];
  assign sc_issue.rs1   = rs1_q[sc_idx];
  assign sc_issue.rs2   = rs2_q[sc_idx];
  assign sc_issue.dest  = dest_q[sc_idx];

  assign mc_issue.valid = |mc_cand;
  assign mc_issue.rob   = rob_q[mc_idx];
  assign mc_issue.rs1   = rs1_q[mc_idx];
  assign mc_issue.rs2   = rs2_q[mc_idx];
  assign mc_issue.dest  = dest_q[mc_idx];

  always_comb begin
    dup_rob = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      for (int j = i + 1; j < QUEUE_DEPTH; j++) begin
        if (vld_q[i] && vld_q[j] && (rob_q[i] == rob_q[j])) dup_rob = 1'b1;
      end
    end
  end

  a_no_disp_when_full : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i) disp_valid_i |-> !disp_busy_o
  ) else $error("dispatch while issue queue full");

  // ROB ids are unique among in-flight ops
  a_unique_rob : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i) !dup_rob
  ) else $error("two queue entries share a rob id");

endmodule

`default_nettype wire

//--- rtl/ixu.sv
////////////////////
// IXU top level
// Issue queue, payload RAM and ALU and multiply pipes
////////////////////
`default_nettype none
`timescale 1ns/10ps

module ixu
  import ixu_cfg_pkg::*;
  import ixu_isa_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8,
  parameter int MC_LATENCY  = 4
) (
  input  logic    core_clock_i,
  input  logic    rst_n_i,
  input  logic    core_flush_i,
  // Dispatch
  input  logic    disp_valid_i,
  input  rob_id_t disp_rob_i,
  input  ixu_op_e disp_op_i,
  input  logic    disp_imm_i,
  input  xlen_t   disp_immediate_i,
  input  preg_t   disp_rs1_i,
  input  preg_t   disp_rs2_i,
  input  preg_t   disp_dest_i,
  input  logic    disp_rs1_rdy_i,
  input  logic    disp_rs2_rdy_i,
  output logic    disp_busy_o,
  // Memory system wakeup
  input  logic    ext_wkp_valid_i,
  input  preg_t   ext_wkp_dest_i,
  // Register file read ports
  output preg_t   sc_rs1_o,
  output preg_t   sc_rs2_o,
  input  xlen_t   sc_rs1_data_i,
  input  xlen_t   sc_rs2_data_i,
  output preg_t   mc_rs1_o,
  output preg_t   mc_rs2_o,
  input  xlen_t   mc_rs1_data_i,
  input  xlen_t   mc_rs2_data_i,
  // ALU writeback and completion
  output logic    sc_wb_valid_o,
  output preg_t   sc_wb_dest_o,
  output xlen_t   sc_wb_data_o,
  output logic    sc_complete_o,
  output rob_id_t sc_rob_o,
  // Multiply writeback and completion
  output logic    mc_wb_valid_o,
  output preg_t   mc_wb_dest_o,
  output xlen_t   mc_wb_data_o,
  output logic    mc_complete_o,
  output rob_id_t mc_rob_o,
  // Exception
  output logic    excp_valid_o,
  output rob_id_t excp_rob_o
);

  ixu_op_e sc_op;
  logic    sc_imm;
  xlen_t   sc_immediate;
  ixu_op_e mc_op;
  logic    mc_busy;

  ixu_issue_if sc_issue ();
  ixu_issue_if mc_issue ();

  ixu_iram iram_i (
    .core_clock_i   (core_clock_i),
    .wr_en_i        (disp_valid_i),
    .wr_rob_i       (disp_rob_i),
    .wr_op_i        (disp_op_i),
    .wr_imm_i       (disp_imm_i),
    .wr_immediate_i (disp_immediate_i),
    .sc_rob_i       (sc_issue.rob),
    .sc_op_o        (sc_op),
    .sc_imm_o       (sc_imm),
    .sc_immediate_o (sc_immediate),
    .mc_rob_i       (mc_issue.rob),
    .mc_op_o        (mc_op),
    // Multiplies take both operands from registers
    .mc_immediate_o ()
  );

  ixu_issue_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_i (
    .core_clock_i    (core_clock_i),
    .rst_n_i         (rst_n_i),
    .core_flush_i    (core_flush_i),
    .disp_valid_i    (disp_valid_i),
    .disp_op_i       (disp_op_i),
    .disp_rob_i      (disp_rob_i),
    .disp_rs1_i      (disp_rs1_i),
    .disp_rs2_i      (disp_rs2_i),
    .disp_dest_i     (disp_dest_i),
    .disp_rs1_rdy_i  (disp_rs1_rdy_i),
    .disp_rs2_rdy_i  (disp_rs2_rdy_i),
    .disp_busy_o     (disp_busy_o),
    .sc_wkp_valid_i  (sc_wb_valid_o),
    .sc_wkp_dest_i   (sc_wb_dest_o),
    .mc_wkp_valid_i  (mc_wb_valid_o),
    .mc_wkp_dest_i   (mc_wb_dest_o),
    .ext_wkp_valid_i (ext_wkp_valid_i),
    .ext_wkp_dest_i  (ext_wkp_dest_i),
    .mc_busy_i       (mc_busy),
    .sc_issue        (sc_issue.queue_mp),
    .mc_issue        (mc_issue.queue_mp)
  );

  ixu_sc_pipe sc_pipe_i (
    .core_clock_i (core_clock_i),
    .rst_n_i      (rst_n_i),
    .core_flush_i (core_flush_i),
    .issue_i      (sc_issue.pipe_mp),
    .op_i         (sc_op),
    .imm_i        (sc_imm),
    .immediate_i  (sc_immediate),
    .rs1_o        (sc_rs1_o),
    .rs2_o        (sc_rs2_o),
    .rs1_data_i   (sc_rs1_data_i),
    .rs2_data_i   (sc_rs2_data_i),
    .wb_valid_o   (sc_wb_valid_o),
    .wb_dest_o    (sc_wb_dest_o),
    .wb_data_o    (sc_wb_data_o),
    .complete_o   (sc_complete_o),
    .rob_o        (sc_rob_o),
    .excp_valid_o (excp_valid_o),
    .excp_rob_o   (excp_rob_o)
  );

  ixu_mc_pipe #(
    .MC_LATENCY (MC_LATENCY)
  ) mc_pipe_i (
    .core_clock_i (core_clock_i),
    .rst_n_i      (rst_n_i),
    .core_flush_i (core_flush_i),
    .issue_i      (mc_issue.pipe_mp),
    .op_i         (mc_op),
    .rs1_o        (mc_rs1_o),
    .rs2_o        (mc_rs2_o),
    .rs1_data_i   (mc_rs1_data_i),
    .rs2_data_i   (mc_rs2_data_i),
    .busy_o       (mc_busy),
    .wb_valid_o   (mc_wb_valid_o),
    .wb_dest_o    (mc_wb_dest_o),
    .wb_data_o    (mc_wb_data_o),
    .complete_o   (mc_complete_o),
    .rob_o        (mc_rob_o)
  );

endmodule

`default_nettype wire

//--- rtl/ixu_iram.sv
////////////////////
// IXU payload RAM
// Opcode and immediate per ROB id, written at dispatch
////////////////////
`default_nettype none
`timescale 1ns/10ps

module ixu_iram
  import ixu_cfg_pkg::*;
  import ixu_isa_pkg::*;
(
  input  logic    core_clock_i,
  // Dispatch write
  input  logic    wr_en_i,
  input  rob_id_t wr_rob_i,
  input  ixu_op_e wr_op_i,
  input  logic    wr_imm_i,
  input  xlen_t   wr_immediate_i,
  // Single-cycle pipe read
  input  rob_id_t sc_rob_i,
  output ixu_op_e sc_op_o,
  output logic    sc_imm_o,
  output xlen_t   sc_immediate_o,
  // Multi-cycle pipe read
  input  rob_id_t mc_rob_i,
  output ixu_op_e mc_op_o,
  output xlen_t   mc_immediate_o
);

  localparam int ENTRIES = 1 << ROB_W;

  ixu_op_e op_mem  [ENTRIES];
  logic    imm_mem [ENTRIES];
  xlen_t   val_mem [ENTRIES];

  always_ff @(posedge core_clock_i) begin
    if (wr_en_i) begin
      op_mem[wr_rob_i]  <= wr_op_i;
      imm_mem[wr_rob_i] <= wr_imm_i;
      val_mem[wr_rob_i] <= wr_immediate_i;
    end
  end

  // Asynchronous reads, used in the issue cycle
  assign sc_op_o        = op_mem[sc_rob_i];
  assign sc_imm_o       = imm_mem[sc_rob_i];
  assign sc_immediate_o = val_mem[sc_rob_i];

  assign mc_op_o        = op_mem[mc_rob_i];
  assign mc_immediate_o = val_mem[mc_rob_i];

endmodule

`default_nettype wire

//--- rtl/ixu_mc_pipe.sv
////////////////////
// IXU multi-cycle pipe
// Unsigned multiply, busy for MC_LATENCY cycles per op
////////////////////
`default_nettype none
`timescale 1ns/10ps

module ixu_mc_pipe
  import ixu_cfg_pkg::*;
  import ixu_isa_pkg::*;
#(
  parameter int MC_LATENCY = 4
) (
  input  logic    core_clock_i,
  input  logic    rst_n_i,
  input  logic    core_flush_i,
  ixu_issue_if.pipe_mp issue_i,
  input  ixu_op_e op_i,
  // Register file read
  output preg_t   rs1_o,
  output preg_t   rs2_o,
  input  xlen_t   rs1_data_i,
  input  xlen_t   rs2_data_i,
  output logic    busy_o,
  // Writeback and completion
  output logic    wb_valid_o,
  output preg_t   wb_dest_o,
  output xlen_t   wb_data_o,
  output logic    complete_o,
  output rob_id_t rob_o
);

  typedef enum logic {
    IDLE,
    BUSY
  } ixu_mc_state_e;

  localparam int CNT_W = $clog2(MC_LATENCY + 1);

  ixu_mc_state_e     state_q;
  ixu_mc_state_e     state_d;
  logic [CNT_W-1:0]  cnt_q;
  logic              start;
  logic              done;
  xlen_t             a_q;
  xlen_t             b_q;
  ixu_op_e           op_q;
  preg_t             dest_q;
  rob_id_t           rob_q;
  logic [2*XLEN-1:0] prod;

  assign rs1_o = issue_i.rs1;
  assign rs2_o = issue_i.rs2;

  assign start = issue_i.valid && (state_q == IDLE) && !core_flush_i;
  // Counter reads k in cycle C+k after issue in C
  assign done  = (state_q == BUSY) && (cnt_q == CNT_W'(MC_LATENCY));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start) state_d = BUSY;
      BUSY: if (done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
    if (core_flush_i) state_d = IDLE;
  end

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start) cnt_q <= CNT_W'(1);
      else if (state_q == BUSY) cnt_q <= cnt_q + 1'b1;
    end
  end

  // Operands captured at issue
  always_ff @(posedge core_clock_i) begin
    if (start) begin
      a_q    <= rs1_data_i;
      b_q    <= rs2_data_i;
      op_q   <= op_i;
      dest_q <= issue_i.dest;
      rob_q  <= issue_i.rob;
    end
  end

  assign prod = {{XLEN{1'b0}}, a_q} * {{XLEN{1'b0}}, b_q};

  assign busy_o     = (state_q == BUSY);
  assign wb_valid_o = done;
  assign complete_o = done;
  assign wb_dest_o  = dest_q;
  assign rob_o      = rob_q;
  assign wb_data_o  = (op_q == OP_MULHU) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

  // Queue must hold multiplies back while busy
  a_no_issue_busy : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i) issue_i.valid |-> !busy_o
  ) else $error("mc issue while pipe busy");

endmodule

`default_nettype wire

//--- rtl/ixu_sc_pipe.sv
////////////////////
// IXU single-cycle pipe
// ALU execute with one registered writeback and exception stage
////////////////////
`default_nettype none
`timescale 1ns/10ps

module ixu_sc_pipe
  import ixu_cfg_pkg::*;
  import ixu_isa_pkg::*;
(
  input  logic    core_clock_i,
  input  logic    rst_n_i,
  input  logic    core_flush_i,
  ixu_issue_if.pipe_mp issue_i,
  // Payload
  input  ixu_op_e op_i,
  input  logic    imm_i,
  input  xlen_t   immediate_i,
  // Register file read
  output preg_t   rs1_o,
  output preg_t   rs2_o,
  input  xlen_t   rs1_data_i,
  input  xlen_t   rs2_data_i,
  // Writeback and completion
  output logic    wb_valid_o,
  output preg_t   wb_dest_o,
  output xlen_t   wb_data_o,
  output logic    complete_o,
  output rob_id_t rob_o,
  // Exception
  output logic    excp_valid_o,
  output rob_id_t excp_rob_o
);

  xlen_t   opb;
  logic    legal;
  logic    go;
  logic    wen_q;
  logic    cmp_q;
  logic    excp_q;
  xlen_t   data_q;
  preg_t   dest_q;
  rob_id_t rob_q;

  assign rs1_o = issue_i.rs1;
  assign rs2_o = issue_i.rs2;

  assign opb   = imm_i ? immediate_i : rs2_data_i;
  assign legal = ixu_op_is_legal(op_i);
  // Work issued in a flush cycle is dropped
  assign go    = issue_i.valid && !core_flush_i;

  always_ff @(posedge core_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wen_q  <= 1'b0;
      cmp_q  <= 1'b0;
      excp_q <= 1'b0;
    end else begin
      wen_q  <= go && legal;
      cmp_q  <= go;
      excp_q <= go && !legal;
    end
  end

  always_ff @(posedge core_clock_i) begin
    data_q <= ixu_alu_eval(op_i, rs1_data_i, opb);
    dest_q <= issue_i.dest;
    rob_q  <= issue_i.rob;
  end

  assign wb_valid_o   = wen_q;
  assign wb_dest_o    = dest_q;
  assign wb_data_o    = data_q;
  assign complete_o   = cmp_q;
  assign rob_o        = rob_q;
  assign excp_valid_o = excp_q;
  assign excp_rob_o   = rob_q;

  // Every completion carries exactly one of write or exception
  a_one_outcome : assert property (
    @(posedge core_clock_i) disable iff (!rst_n_i)
    go |=> complete_o && (wb_valid_o != excp_valid_o)
  ) else $error("sc completion without a single outcome");

endmodule

`default_nettype wire
